// File: Makefile
# Verilator flow for the instruction fetch front end

TOP = fetch_tb

.PHONY: all lint sim clean

all: sim

# Lint the design on its own
lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module fetch_top -f build.f

# Build and run, pass only when the pass line shows up
sim:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module $(TOP) -f build.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+testbench
hdl/fetch_pkg.sv
hdl/fetch_ctrl_if.sv
hdl/fetch_data_if.sv
hdl/pc_gen.sv
hdl/instr_rom.sv
hdl/instr_predecode.sv
hdl/if_id_reg.sv
hdl/fetch_top.sv
testbench/fetch_tb.sv

// File: hdl/fetch_ctrl_if.sv
/*
 * Fetch control bundle
 * Stall strobes and redirect requests from the rest of the pipeline,
 * seen by the PC generator and by the IF/ID register
 */
`timescale 1ns/1ps

interface fetch_ctrl_if;
	import fetch_pkg::*;

	logic hold_pc;               // Freeze program counter
	logic hold_if;               // Freeze IF/ID outputs
	logic br;                    // Taken branch strobe
	logic except;                // Exception strobe
	logic [XLEN-1:0] pc_branch;  // Branch target

	// PC generator sees everything
	modport pc_side (
		input hold_pc, hold_if, br, except, pc_branch
	);

	// Pipeline register only needs stall and flush
	modport stage_side (
		input hold_if, br, except
	);

endinterface

// File: hdl/fetch_data_if.sv
/*
 * Fetch data bundle
 * Current PC, the word read at it, its class and the issue flag,
 * gathered by the front end and captured by the IF/ID register
 */
`timescale 1ns/1ps

interface fetch_data_if;
	import fetch_pkg::*;

	logic [XLEN-1:0] pc;         // Current program counter
	logic [XLEN-1:0] inst;       // ROM word at pc
	instr_class_e inst_class;    // Predecoded class of inst
	logic issue;                 // PC is advancing this cycle

	// PC generator owns pc and issue
	modport pc_source (
		output pc, issue
	);

	// IF/ID register reads the whole entry
	modport sink (
		input pc, inst, inst_class, issue
	);

endinterface

// File: hdl/fetch_pkg.sv
/*
 * Fetch front end shared definitions
 * Widths, reset and exception vectors, ROM depth, the NOP word,
 * RISC-V major opcodes and the instruction class carried to decode
 */
package fetch_pkg;

	// --------------------
	// Widths and vectors
	// --------------------
	localparam int XLEN = 32;                                 // Data and address width
	localparam int OPCODE_W = 7;                              // Major opcode field
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;              // One instruction word

	localparam logic [XLEN-1:0] RESET_VECTOR = 32'h4000_0000;     // PC after reset
	localparam logic [XLEN-1:0] EXCEPTION_VECTOR = 32'h4000_0040; // Trap target

	// --------------------
	// Instruction ROM
	// --------------------
	localparam int ROM_WORDS = 32;                            // Depth in words
	localparam int ROM_ADDR_W = $clog2(ROM_WORDS);            // Word index width

	// addi x0,x0,0
	localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;

	// --------------------
	// RISC-V major opcodes
	// --------------------
	typedef enum logic [OPCODE_W-1:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,  // Conditional branches
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,  // Register-immediate ALU
		OP     = 7'b0110011,  // Register-register ALU
		SYSTEM = 7'b1110011   // ecall, ebreak, csr
	} opcode_e;

	// --------------------
	// Instruction classes
	// --------------------
	// Coarse class handed to decode along with the word
	typedef enum logic [2:0] {
		CLASS_ALU     = 3'd0,
		CLASS_LOAD    = 3'd1,
		CLASS_STORE   = 3'd2,
		CLASS_BRANCH  = 3'd3,
		CLASS_JUMP    = 3'd4,  // jal and jalr
		CLASS_SYSTEM  = 3'd5,
		CLASS_ILLEGAL = 3'd6,  // Unknown opcode or compressed
		CLASS_BUBBLE  = 3'd7   // Empty pipeline slot
	} instr_class_e;

endpackage

// File: hdl/fetch_top.sv
/*
 * Instruction fetch front end
 * PC generator, instruction ROM and predecoder feeding the IF/ID
 * register. Stall and redirect controls come in as plain ports.
 */
`timescale 1ns/1ps

module fetch_top (
	input  logic clk,
	input  logic rst_n,
	input  logic hold_pc,
	input  logic hold_if,
	input  logic br,
	input  logic except,
	input  logic [fetch_pkg::XLEN-1:0] pc_branch,
	output logic [fetch_pkg::XLEN-1:0] pc_out,
	output logic [fetch_pkg::XLEN-1:0] inst_out,
	output fetch_pkg::instr_class_e class_out,
	output logic valid_out
);

	// --------------------
	// Internal bundles
	// --------------------
	fetch_ctrl_if ctrl_bus ();
	fetch_data_if fetch_bus ();

	// Controls straight from the pins
	assign ctrl_bus.hold_pc   = hold_pc;
	assign ctrl_bus.hold_if   = hold_if;
	assign ctrl_bus.br        = br;
	assign ctrl_bus.except    = except;
	assign ctrl_bus.pc_branch = pc_branch;

	// --------------------
	// Fetch path
	// --------------------
	pc_gen pc_gen_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl_bus.pc_side),
		.fetch (fetch_bus.pc_source)
	);

	instr_rom instr_rom_i (
		.pc   (fetch_bus.pc),     // Same-cycle read
		.inst (fetch_bus.inst)
	);

	instr_predecode instr_predecode_i (
		.inst       (fetch_bus.inst),
		.inst_class (fetch_bus.inst_class)
	);

	// --------------------
	// Pipeline register
	// --------------------
	if_id_reg if_id_reg_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl_bus.stage_side),
		.fetch     (fetch_bus.sink),
		.pc_out    (pc_out),
		.inst_out  (inst_out),
		.class_out (class_out),
		.valid_out (valid_out)
	);

endmodule

// File: hdl/if_id_reg.sv
/*
 * Fetch to decode pipeline register
 * Captures the fetched entry each cycle unless stalled, and
 * loads a bubble on any redirect, even during a stall
 */
`timescale 1ns/1ps

module if_id_reg (
	input  logic clk,
	input  logic rst_n,
	fetch_ctrl_if.stage_side ctrl,
	fetch_data_if.sink fetch,
	output logic [fetch_pkg::XLEN-1:0] pc_out,
	output logic [fetch_pkg::XLEN-1:0] inst_out,
	output fetch_pkg::instr_class_e class_out,
	output logic valid_out
);
	import fetch_pkg::*;

	logic redirect;   // Flush request

	assign redirect = ctrl.br | ctrl.except;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc_out    <= RESET_VECTOR;
			inst_out  <= NOP_INST;
			class_out <= CLASS_BUBBLE;
			valid_out <= 1'b0;
		end
		else if (redirect)
		begin
			// Wrong-path word dropped, pc_out left as it was
			inst_out  <= NOP_INST;
			class_out <= CLASS_BUBBLE;
			valid_out <= 1'b0;
		end
		else if (!ctrl.hold_if)
		begin
			pc_out    <= fetch.pc;
			valid_out <= fetch.issue;
			if (fetch.issue)
			begin
				inst_out  <= fetch.inst;
				class_out <= fetch.inst_class;
			end
			else
			begin
				inst_out  <= NOP_INST;      // PC held, slot is empty
				class_out <= CLASS_BUBBLE;
			end
		end
		// hold_if without redirect keeps everything
	end

endmodule

// File: hdl/instr_predecode.sv
/*
 * Instruction predecoder
 * Sorts a fetched word into a coarse class by its major opcode.
 * Compressed or unknown encodings come out as illegal.
 */
`timescale 1ns/1ps

module instr_predecode (
	input  logic [fetch_pkg::XLEN-1:0] inst,
	output fetch_pkg::instr_class_e inst_class
);
	import fetch_pkg::*;

	opcode_e opcode;      // Major opcode view of the low bits
	logic full_width;     // 32-bit encoding marker

	assign opcode = opcode_e'(inst[OPCODE_W-1:0]);
	assign full_width = (inst[1:0] == 2'b11);

	// --------------------
	// Class lookup
	// --------------------
	always_comb
	begin
		if (!full_width)
			inst_class = CLASS_ILLEGAL;        // 16-bit forms not supported
		else
		begin
			unique case (opcode)
				LUI,
				AUIPC,
				OP_IMM,
				OP:
					inst_class = CLASS_ALU;
				LOAD:
					inst_class = CLASS_LOAD;
				STORE:
					inst_class = CLASS_STORE;
				BRANCH:
					inst_class = CLASS_BRANCH;
				JAL,
				JALR:
					inst_class = CLASS_JUMP;       // Unconditional transfers
				SYSTEM:
					inst_class = CLASS_SYSTEM;
				default:
					inst_class = CLASS_ILLEGAL;    // Fences, atomics, FP, junk
			endcase
		end
	end

endmodule

// File: hdl/instr_rom.sv
/*
 * Instruction ROM
 * Program image loaded from a hex file, read combinationally.
 * Indexed by word offset from the reset vector; anything outside
 * the image reads back as a NOP.
 */
`timescale 1ns/1ps

module instr_rom (
	input  logic [fetch_pkg::XLEN-1:0] pc,
	output logic [fetch_pkg::XLEN-1:0] inst
);
	import fetch_pkg::*;

	logic [XLEN-1:0] rom_mem [ROM_WORDS];   // Program image

	logic [XLEN-1:0] offset;     // Byte offset from reset vector
	logic [XLEN-1:0] word_idx;   // Word offset
	logic in_range;              // Inside the image

	// Image contents
	initial
	begin
		$readmemh("program.hex", rom_mem);
	end

	// --------------------
	// Address decode
	// --------------------
	assign offset = pc - RESET_VECTOR;      // Wraps when pc is below the vector
	assign word_idx = offset >> 2;

	// Below-vector PCs wrap to huge word offsets and fall outside as well
	assign in_range = (word_idx < XLEN'(ROM_WORDS));

	// --------------------
	// Read port
	// --------------------
	assign inst = in_range ? rom_mem[word_idx[ROM_ADDR_W-1:0]] : NOP_INST;

endmodule

// File: hdl/pc_gen.sv
/*
 * Program counter generator
 * Holds the PC and selects the next one. Exception beats branch,
 * branch beats hold, otherwise step by one word.
 * Also flags whether the current PC is being issued.
 */
`timescale 1ns/1ps

module pc_gen (
	input  logic clk,
	input  logic rst_n,
	fetch_ctrl_if.pc_side ctrl,
	fetch_data_if.pc_source fetch
);
	import fetch_pkg::*;

	logic [XLEN-1:0] pc_q;      // Current PC
	logic [XLEN-1:0] pc_next;   // Selected next PC
	logic redirect;             // Either redirect strobe

	assign redirect = ctrl.br | ctrl.except;

	// --------------------
	// Next PC selection
	// --------------------
	always_comb
	begin
		if (ctrl.except)
			pc_next = EXCEPTION_VECTOR;   // Highest priority
		else if (ctrl.br)
			pc_next = ctrl.pc_branch;     // Taken branch
		else if (ctrl.hold_pc)
			pc_next = pc_q;               // Stalled
		else
			pc_next = pc_q + PC_STEP;     // Sequential
	end

	// --------------------
	// PC register
	// --------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc_q <= RESET_VECTOR;
		else
			pc_q <= pc_next;
	end

	assign fetch.pc = pc_q;

	// A held PC is issued only once, on the cycle it moves on
	// Redirects always move it, so they count as issue too
	assign fetch.issue = ~ctrl.hold_pc | redirect;

endmodule

// File: program.hex
// One 32-bit instruction word per line, word 0 at the reset vector
00000013
00100093
123450b7
00001117
002081b3
0000a203
0040a223
00208463
008000ef
00008067
00000073
00100073
0000000f
00004501
ffffffff
00000000
40208233
0ff0f293
fe209ee3
00c12303
00612623
30002373
0080006f
000280e7
0000202f
00001537
00a50533
00054583
00b50023
00a5d463
12345678
0000006f

// File: testbench/fetch_tb_model.svh
/*
 * Reference model of the fetch front end
 * Cycle model of the PC, ROM image, predecoder and IF/ID register,
 * stepped by the testbench once per rising clock edge
 */
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

logic [XLEN-1:0] model_rom [ROM_WORDS];   // Same image as the DUT
logic [XLEN-1:0] model_pc;                // Expected program counter
logic [XLEN-1:0] model_pc_out;
logic [XLEN-1:0] model_inst_out;
instr_class_e model_class_out;
logic model_valid_out;

initial
begin
	$readmemh("program.hex", model_rom);
end

// Word at a PC, NOP outside the image
function automatic logic [XLEN-1:0] model_fetch(input logic [XLEN-1:0] pc);
	int idx;
	if (pc < RESET_VECTOR)
		return NOP_INST;
	idx = int'((pc - RESET_VECTOR) >> 2);
	if (idx >= ROM_WORDS)
		return NOP_INST;
	return model_rom[idx];
endfunction

// Class from the major opcode
function automatic instr_class_e model_class(input logic [XLEN-1:0] inst);
	if (inst[1:0] != 2'b11)
		return CLASS_ILLEGAL;     // Compressed forms
	case (inst[6:0])
		LUI, AUIPC, OP_IMM, OP: return CLASS_ALU;
		LOAD:                   return CLASS_LOAD;
		STORE:                  return CLASS_STORE;
		BRANCH:                 return CLASS_BRANCH;
		JAL, JALR:              return CLASS_JUMP;
		SYSTEM:                 return CLASS_SYSTEM;
		default:                return CLASS_ILLEGAL;
	endcase
endfunction

task automatic model_reset();
	model_pc = RESET_VECTOR;
	model_pc_out = RESET_VECTOR;
	model_inst_out = NOP_INST;
	model_class_out = CLASS_BUBBLE;
	model_valid_out = 1'b0;
endtask

// One rising edge with the given controls
task automatic model_step(input logic hp, input logic hi, input logic b, input logic e,
		input logic [XLEN-1:0] tgt);
	logic redirect;
	logic issue;
	redirect = b | e;
	issue = !hp | redirect;     // Held PC goes out once
	if (redirect)
	begin
		model_inst_out = NOP_INST;   // Flush, pc_out kept
		model_class_out = CLASS_BUBBLE;
		model_valid_out = 1'b0;
	end
	else if (!hi)
	begin
		model_pc_out = model_pc;
		model_valid_out = issue;
		model_inst_out = issue ? model_fetch(model_pc) : NOP_INST;
		model_class_out = issue ? model_class(model_fetch(model_pc)) : CLASS_BUBBLE;
	end
	if (e)
		model_pc = EXCEPTION_VECTOR;
	else if (b)
		model_pc = tgt;
	else if (!hp)
		model_pc = model_pc + 32'd4;
endtask

`endif

// File: testbench/fetch_tb.sv
/*
 * Testbench for the instruction fetch front end
 * LFSR-driven branches, exceptions and holds against a cycle model,
 * with a cycle counter guarding against a hung run
 */
`timescale 1ns/1ps

module fetch_tb;
	import fetch_pkg::*;

	localparam int TEST_CYCLES = 900;                 // Rough total over all tests
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic clk;
	logic rst_n;
	logic hold_pc;
	logic hold_if;
	logic br;
	logic except;
	logic [XLEN-1:0] pc_branch;
	logic [XLEN-1:0] pc_out;
	logic [XLEN-1:0] inst_out;
	instr_class_e class_out;
	logic valid_out;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int cycle_count = 0;
	logic [31:0] lfsr_state;

	`include "fetch_tb_model.svh"

	fetch_top fetch_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.hold_pc   (hold_pc),
		.hold_if   (hold_if),
		.br        (br),
		.except    (except),
		.pc_branch (pc_branch),
		.pc_out    (pc_out),
		.inst_out  (inst_out),
		.class_out (class_out),
		.valid_out (valid_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: no result after %0d clock cycles", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	// --------------------
	// Random source
	// --------------------
	function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);   // Galois form shifting right
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_advance(lfsr_state);
		end
	endtask

	// --------------------
	// Checking
	// --------------------
	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at time %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_outputs();
		check_eq(pc_out, model_pc_out, "pc_out");
		check_eq(inst_out, model_inst_out, "inst_out");
		check_eq(32'(class_out), 32'(model_class_out), "class_out");
		check_eq(32'(valid_out), 32'(model_valid_out), "valid_out");
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		$display("%-12s done, %0d errors", name, errors - errors_before);
	endtask

	// Inputs land 2 ns after the edge, outputs read 2 ns after the next
	task automatic run_cycle(input logic hp, input logic hi, input logic b, input logic e,
			input logic [XLEN-1:0] tgt);
		hold_pc = hp;
		hold_if = hi;
		br = b;
		except = e;
		pc_branch = tgt;
		@(posedge clk);
		model_step(hp, hi, b, e, tgt);
		#2;
		compare_outputs();
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic test_reset();
		int mark;
		mark = errors;
		repeat (8)
		begin
			@(posedge clk);
			#2;
			compare_outputs();
			check_eq(pc_out, RESET_VECTOR, "pc_out in reset");
			check_eq(32'(valid_out), 32'd0, "valid_out in reset");
		end
		rst_n = 1'b1;
		compare_outputs();          // Still a bubble before the first edge
		run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		check_eq(pc_out, RESET_VECTOR, "first pc after reset");
		check_eq(inst_out, model_rom[0], "first word after reset");
		check_eq(32'(valid_out), 32'd1, "first valid after reset");
		finish_test("reset", mark);
	endtask

	task automatic test_sequential();
		int mark;
		logic [XLEN-1:0] prev_pc;
		mark = errors;
		for (int n = 0; n < 40; n++)
		begin
			prev_pc = model_pc_out;
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
			check_eq(pc_out, prev_pc + 32'd4, "sequential step");
			if (pc_out >= RESET_VECTOR + 32'd128)
			begin
				check_eq(inst_out, NOP_INST, "word past ROM end");
				check_eq(32'(class_out), 32'(CLASS_ALU), "class past ROM end");
			end
		end
		finish_test("sequential", mark);
	endtask

	task automatic test_branches();
		int mark;
		int gap;
		logic [31:0] r;
		logic [XLEN-1:0] target;
		mark = errors;
		for (int n = 0; n < 60; n++)
		begin
			draw_bits(6, r);
			target = RESET_VECTOR - 32'd32 + {r[29:0], 2'b00};   // Spans below and past the image
			run_cycle(1'b0, 1'b0, 1'b1, 1'b0, target);
			check_eq(32'(valid_out), 32'd0, "bubble after branch");
			draw_bits(2, r);
			gap = int'(r) + 1;
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
			check_eq(pc_out, target, "branch target pc");
			check_eq(inst_out, model_fetch(target), "branch target word");
			repeat (gap - 1)
				run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		end
		finish_test("branches", mark);
	endtask

	task automatic test_exceptions();
		int mark;
		logic with_br;
		logic [31:0] r;
		logic [XLEN-1:0] target;
		mark = errors;
		for (int n = 0; n < 20; n++)
		begin
			draw_bits(1, r);
			with_br = r[0];             // Branch in the same cycle about half the time
			draw_bits(6, r);
			target = RESET_VECTOR + {r[29:0], 2'b00};
			run_cycle(1'b0, 1'b0, with_br, 1'b1, target);
			check_eq(32'(valid_out), 32'd0, "bubble after exception");
			check_eq(32'(class_out), 32'(CLASS_BUBBLE), "class after exception");
			run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
			check_eq(pc_out, EXCEPTION_VECTOR, "exception target pc");
			repeat (2)
				run_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
		end
		finish_test("exceptions", mark);
	endtask

	task automatic test_holds();
		int mark;
		logic hp;
		logic hi;
		logic b;
		logic e;
		logic [31:0] r;
		logic [XLEN-1:0] target;
		logic [XLEN-1:0] prev_pc;
		logic [XLEN-1:0] prev_inst;
		mark = errors;
		for (int n = 0; n < 400; n++)
		begin
			draw_bits(1, r);
			hp = r[0];
			draw_bits(1, r);
			hi = r[0];
			draw_bits(4, r);
			b = (r[3:0] == 4'd0);       // Rare redirects
			e = (r[3:0] == 4'd1);
			draw_bits(6, r);
			target = RESET_VECTOR + {r[29:0], 2'b00};
			prev_pc = model_pc_out;
			prev_inst = model_inst_out;
			run_cycle(hp, hi, b, e, target);
			if (b || e)
				check_eq(32'(valid_out), 32'd0, "redirect under hold");
			else if (hi)
			begin
				check_eq(pc_out, prev_pc, "pc_out frozen");
				check_eq(inst_out, prev_inst, "inst_out frozen");
			end
			else if (hp)
				check_eq(32'(valid_out), 32'd0, "invalid entry under hold_pc");
		end
		finish_test("holds", mark);
	endtask

	// --------------------
	// Sequence
	// --------------------
	initial
	begin
		rst_n = 1'b0;
		hold_pc = 1'b0;
		hold_if = 1'b0;
		br = 1'b0;
		except = 1'b0;
		pc_branch = '0;
		lfsr_state = 32'h96e1;
		model_reset();

		test_reset();
		test_sequential();
		test_branches();
		test_exceptions();
		test_holds();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
